/* rtl/pcs_rx_pkg.sv */
package pcs_rx_pkg;

        // ##########################################################
        // Widths with a meaning
        // ##########################################################

        typedef logic [1:0] sync_hdr_t;
        typedef logic [7:0] err_cnt_t;          // Errored blocks, saturating.
        typedef logic [7:0] event_cnt_t;        // Hi BER events, saturating.

        // Legal 64b/66b sync headers.
        localparam sync_hdr_t SYNC_DATA = 2'b01;
        localparam sync_hdr_t SYNC_CTRL = 2'b10;

        // ##########################################################
        // Structs between stages
        // ##########################################################

        // Per-block header result.
        typedef struct packed
        {
                logic valid;
                logic invalid_hdr;
        } hdr_result_t;

        // Status word at the top output.
        typedef struct packed
        {
                logic block_lock;
                logic hi_ber;
                logic link_up;
                logic lock_latched_low;
        } rx_status_t;

endpackage

/* rtl/sync_header_check.sv */
`timescale 1ns/1ps

module sync_header_check
(
        input  logic                    i_clock,
        input  logic                    i_rst_n,
        input  logic                    i_valid,
        input  pcs_rx_pkg::sync_hdr_t   i_sync_hdr,
        output pcs_rx_pkg::hdr_result_t o_hdr
);

        logic hdr_legal;
        logic invalid_hdr;

        // Only 01 and 10 are legal.
        assign hdr_legal = (i_sync_hdr == pcs_rx_pkg::SYNC_DATA) ||
                           (i_sync_hdr == pcs_rx_pkg::SYNC_CTRL);

        assign invalid_hdr = i_valid & ~hdr_legal;      // Qualified by the strobe.

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        o_hdr.valid       <= 1'b0;
                        o_hdr.invalid_hdr <= 1'b0;
                end
                else
                begin
                        o_hdr.valid       <= i_valid;
                        o_hdr.invalid_hdr <= invalid_hdr;
                end
        end

endmodule

/* rtl/block_lock_fsm.sv */
`timescale 1ns/1ps

module block_lock_fsm
#(
        parameter int LOCK_COUNT    = 64,
        parameter int LOCK_WINDOW   = 64,
        parameter int UNLOCK_ERRORS = 16
)
(
        input  logic                    i_clock,
        input  logic                    i_rst_n,
        input  pcs_rx_pkg::hdr_result_t i_hdr,
        output logic                    o_block_lock
);

        localparam int GOOD_W = $clog2(LOCK_COUNT + 1);
        localparam int WIN_W  = $clog2(LOCK_WINDOW + 1);
        localparam int INV_W  = $clog2(UNLOCK_ERRORS + 1);

        typedef enum logic [1:0]
        {
                RESET_CNT,
                UNLOCKED,
                LOCKED
        } lock_state_t;

        lock_state_t       state, next_state;
        logic [GOOD_W-1:0] good_cnt, next_good_cnt;
        logic [WIN_W-1:0]  win_cnt, next_win_cnt;
        logic [INV_W-1:0]  inv_cnt, next_inv_cnt;
        logic              good_hdr;
        logic              bad_hdr;

        assign good_hdr = i_hdr.valid & ~i_hdr.invalid_hdr;
        assign bad_hdr  = i_hdr.valid &  i_hdr.invalid_hdr;

        // ##########################################################
        // Next state
        // ##########################################################

        always_comb
        begin
                next_state    = state;
                next_good_cnt = good_cnt;
                next_win_cnt  = win_cnt;
                next_inv_cnt  = inv_cnt;

                case (state)
                        RESET_CNT:
                        begin
                                next_state    = UNLOCKED;
                                next_win_cnt  = '0;
                                next_inv_cnt  = '0;
                                next_good_cnt = good_hdr ? GOOD_W'(1) : '0; // Block here still counts.
                        end

                        UNLOCKED:
                        begin
                                if (bad_hdr)
                                        next_good_cnt = '0;
                                else if (good_hdr)
                                begin
                                        if (good_cnt >= GOOD_W'(LOCK_COUNT - 1))
                                        begin
                                                next_state    = LOCKED;
                                                next_good_cnt = '0;
                                        end
                                        else
                                                next_good_cnt = good_cnt + 1'b1;
                                end
                        end

                        LOCKED:
                        begin
                                if (bad_hdr && inv_cnt == INV_W'(UNLOCK_ERRORS - 1))
                                        next_state = RESET_CNT;         // Too many errors.
                                else if (i_hdr.valid && win_cnt == WIN_W'(LOCK_WINDOW - 1))
                                begin
                                        next_win_cnt = '0;
                                        next_inv_cnt = '0;
                                end
                                else if (i_hdr.valid)
                                begin
                                        next_win_cnt = win_cnt + 1'b1;
                                        next_inv_cnt = inv_cnt + INV_W'(bad_hdr);
                                end
                        end

                        default:
                                next_state = RESET_CNT;
                endcase
        end

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        state    <= RESET_CNT;
                        good_cnt <= '0;
                        win_cnt  <= '0;
                        inv_cnt  <= '0;
                end
                else
                begin
                        state    <= next_state;
                        good_cnt <= next_good_cnt;
                        win_cnt  <= next_win_cnt;
                        inv_cnt  <= next_inv_cnt;
                end
        end

        assign o_block_lock = (state == LOCKED);

endmodule

/* rtl/ber_monitor.sv */
`timescale 1ns/1ps

module ber_monitor
#(
        parameter int BER_WINDOW   = 1024,
        parameter int HI_BER_COUNT = 97
)
(
        input  logic                    i_clock,
        input  logic                    i_rst_n,
        input  pcs_rx_pkg::hdr_result_t i_hdr,
        input  logic                    i_block_lock,
        input  logic                    i_test_mode,
        output logic                    o_hi_ber
);

        localparam int CNT_W = $clog2(HI_BER_COUNT + 1);
        localparam int WIN_W = $clog2(BER_WINDOW + 1);

        typedef enum logic [1:0]
        {
                INIT,
                TEST,
                HI_BER
        } ber_state_t;

        ber_state_t       state, next_state;
        logic [CNT_W-1:0] ber_cnt, next_ber_cnt;
        logic [CNT_W-1:0] ber_sum;
        logic [WIN_W-1:0] win_cnt, next_win_cnt;
        logic             bad_hdr;
        logic             window_end;
        logic             reached;

        assign bad_hdr    = i_hdr.valid & i_hdr.invalid_hdr;
        assign window_end = i_hdr.valid && (win_cnt == WIN_W'(BER_WINDOW - 1));

        // Saturates at the threshold.
        assign ber_sum = (ber_cnt == CNT_W'(HI_BER_COUNT)) ? ber_cnt :
                                                             ber_cnt + CNT_W'(bad_hdr);
        assign reached = (ber_sum >= CNT_W'(HI_BER_COUNT));

        // ##########################################################
        // Next state
        // ##########################################################

        always_comb
        begin
                next_state   = state;
                next_ber_cnt = ber_cnt;
                next_win_cnt = win_cnt;

                if (!i_block_lock || i_test_mode)
                begin
                        next_state   = INIT;            // Held until lock and no test.
                        next_ber_cnt = '0;
                        next_win_cnt = '0;
                end
                else if (state == INIT)
                begin
                        next_state   = TEST;
                        next_ber_cnt = '0;
                        next_win_cnt = '0;
                end
                else if (window_end)
                begin
                        // New window; hi_ber only holds if this one was bad.
                        next_state   = reached ? HI_BER : TEST;
                        next_ber_cnt = '0;
                        next_win_cnt = '0;
                end
                else if (i_hdr.valid)
                begin
                        next_ber_cnt = ber_sum;
                        next_win_cnt = win_cnt + 1'b1;
                        if (reached)
                                next_state = HI_BER;
                end
        end

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        state    <= INIT;
                        ber_cnt  <= '0;
                        win_cnt  <= '0;
                        o_hi_ber <= 1'b0;
                end
                else
                begin
                        state    <= next_state;
                        ber_cnt  <= next_ber_cnt;
                        win_cnt  <= next_win_cnt;
                        o_hi_ber <= (next_state == HI_BER);
                end
        end

endmodule

/* rtl/rx_status.sv */
`timescale 1ns/1ps

module rx_status
(
        input  logic                    i_clock,
        input  logic                    i_rst_n,
        input  pcs_rx_pkg::hdr_result_t i_hdr,
        input  logic                    i_block_lock,
        input  logic                    i_hi_ber,
        input  logic                    i_status_clear,
        output pcs_rx_pkg::rx_status_t  o_status,
        output pcs_rx_pkg::err_cnt_t    o_err_blocks,
        output pcs_rx_pkg::event_cnt_t  o_hi_ber_events
);

        logic err_pend;         // Delayed to line up with the lock stage.
        logic hi_ber_rise;
        logic latched_low_next;

        // Previous hi_ber is the registered status bit.
        assign hi_ber_rise = i_hi_ber & ~o_status.hi_ber;

        assign latched_low_next = !i_block_lock ? 1'b1 :
                                  i_status_clear ? 1'b0 : o_status.lock_latched_low;

        // ##########################################################
        // Status word and counters
        // ##########################################################

        always_ff @(posedge i_clock or negedge i_rst_n)
        begin
                if (!i_rst_n)
                begin
                        err_pend        <= 1'b0;
                        o_status        <= '{block_lock: 1'b0, hi_ber: 1'b0,
                                             link_up: 1'b0, lock_latched_low: 1'b1};
                        o_err_blocks    <= '0;
                        o_hi_ber_events <= '0;
                end
                else
                begin
                        err_pend <= i_hdr.valid & i_hdr.invalid_hdr & i_block_lock;

                        o_status.block_lock       <= i_block_lock;
                        o_status.hi_ber           <= i_hi_ber;
                        o_status.link_up          <= i_block_lock & ~i_hi_ber;
                        o_status.lock_latched_low <= latched_low_next;

                        // Clear wins over an increment.
                        if (i_status_clear)
                                o_err_blocks <= '0;
                        else if (err_pend && o_err_blocks != '1)
                                o_err_blocks <= o_err_blocks + 1'b1;

                        if (i_status_clear)
                                o_hi_ber_events <= '0;
                        else if (hi_ber_rise && o_hi_ber_events != '1)
                                o_hi_ber_events <= o_hi_ber_events + 1'b1;
                end
        end

endmodule

/* rtl/pcs_rx_monitor.sv */
`timescale 1ns/1ps

module pcs_rx_monitor
#(
        parameter int LOCK_COUNT    = 64,
        parameter int LOCK_WINDOW   = 64,
        parameter int UNLOCK_ERRORS = 16,
        parameter int BER_WINDOW    = 1024,
        parameter int HI_BER_COUNT  = 97
)
(
        input  logic                   i_clock,
        input  logic                   i_rst_n,
        input  logic                   i_valid,
        input  pcs_rx_pkg::sync_hdr_t  i_sync_hdr,
        input  logic                   i_test_mode,
        input  logic                   i_status_clear,
        output pcs_rx_pkg::rx_status_t o_status,
        output pcs_rx_pkg::err_cnt_t   o_err_blocks,
        output pcs_rx_pkg::event_cnt_t o_hi_ber_events
);

        pcs_rx_pkg::hdr_result_t hdr;
        logic                    block_lock;
        logic                    hi_ber;

        // Decode.
        sync_header_check u_sync_header_check
        (
                .i_clock    (i_clock),
                .i_rst_n    (i_rst_n),
                .i_valid    (i_valid),
                .i_sync_hdr (i_sync_hdr),
                .o_hdr      (hdr)
        );

        block_lock_fsm
        #(
                .LOCK_COUNT    (LOCK_COUNT),
                .LOCK_WINDOW   (LOCK_WINDOW),
                .UNLOCK_ERRORS (UNLOCK_ERRORS)
        )
        u_block_lock_fsm
        (
                .i_clock      (i_clock),
                .i_rst_n      (i_rst_n),
                .i_hdr        (hdr),
                .o_block_lock (block_lock)
        );

        ber_monitor
        #(
                .BER_WINDOW   (BER_WINDOW),
                .HI_BER_COUNT (HI_BER_COUNT)
        )
        u_ber_monitor
        (
                .i_clock      (i_clock),
                .i_rst_n      (i_rst_n),
                .i_hdr        (hdr),
                .i_block_lock (block_lock),
                .i_test_mode  (i_test_mode),
                .o_hi_ber     (hi_ber)
        );

        // Result stage.
        rx_status u_rx_status
        (
                .i_clock         (i_clock),
                .i_rst_n         (i_rst_n),
                .i_hdr           (hdr),
                .i_block_lock    (block_lock),
                .i_hi_ber        (hi_ber),
                .i_status_clear  (i_status_clear),
                .o_status        (o_status),
                .o_err_blocks    (o_err_blocks),
                .o_hi_ber_events (o_hi_ber_events)
        );

endmodule

/* dv/tb_pcs_rx_monitor.sv */
`timescale 1ns/1ps

module tb_pcs_rx_monitor;

        localparam int LOCK_COUNT  = 8;
        localparam int DRAIN       = 4;         // Pipeline depth plus one.
        localparam int WAIT_CYCLES = 8;
        localparam int LOCK_BIT    = 3;         // Bit positions in o_status.
        localparam int HI_BER_BIT  = 2;

        logic                   i_clock;
        logic                   i_rst_n;
        logic                   i_valid;
        pcs_rx_pkg::sync_hdr_t  i_sync_hdr;
        logic                   i_test_mode;
        logic                   i_status_clear;
        pcs_rx_pkg::rx_status_t o_status;
        pcs_rx_pkg::err_cnt_t   o_err_blocks;
        pcs_rx_pkg::event_cnt_t o_hi_ber_events;

        integer seed = 32'h5a51_c7cf;
        int     errors = 0;
        int     tests = 0;
        int     test_errors;

        pcs_rx_monitor
        #(
                .LOCK_COUNT    (LOCK_COUNT),
                .LOCK_WINDOW   (16),
                .UNLOCK_ERRORS (4),
                .BER_WINDOW    (32),
                .HI_BER_COUNT  (6)
        )
        UUT (.*);

        always #20 i_clock = ~i_clock;

        // ##########################################################
        // Helpers
        // ##########################################################

        task automatic report_mismatch(input string name, input logic [7:0] got,
                                       input logic [7:0] exp);
                $display("Mismatch %s: got %02h, expected %02h", name, got, exp);
                errors++;
        endtask

        function automatic logic [7:0] saturate(input int n);
                return (n > 255) ? 8'hff : 8'(n);
        endfunction

        task automatic check_outputs(input logic lock, input logic hi_ber, input logic latched,
                                     input logic [7:0] err, input logic [7:0] events);
                logic [3:0] exp_status;
                exp_status = {lock, hi_ber, lock & ~hi_ber, latched};  // Link up rule.
                if (o_status != exp_status)
                        report_mismatch("o_status", {4'h0, o_status}, {4'h0, exp_status});
                if (o_err_blocks != err)
                        report_mismatch("o_err_blocks", o_err_blocks, err);
                if (o_hi_ber_events != events)
                        report_mismatch("o_hi_ber_events", o_hi_ber_events, events);
        endtask

        // Back to back blocks, entered 1 ns after an edge.
        task automatic send_blocks(input int n, input logic bad);
                repeat (n)
                begin
                        if (bad)
                                i_sync_hdr = ($random(seed) & 1) ? 2'b11 : 2'b00;
                        else
                                i_sync_hdr = ($random(seed) & 1) ? pcs_rx_pkg::SYNC_CTRL :
                                                                   pcs_rx_pkg::SYNC_DATA;
                        i_valid = 1'b1;
                        @(posedge i_clock);
                        #1;
                        i_valid = 1'b0;
                end
        endtask

        task automatic idle(input int n);
                repeat (n)
                begin
                        @(posedge i_clock);
                        #1;
                end
        endtask

        task automatic wait_status(input int idx, input logic value, input int timeout);
                int n;
                n = 0;
                while (o_status[idx] != value && n < timeout)
                begin
                        @(posedge i_clock);
                        #1;
                        n++;
                end
                if (o_status[idx] != value)
                begin
                        $display("Timeout: status bit %0d did not become %0d", idx, value);
                        errors++;
                end
        endtask

        task automatic apply_reset();
                test_errors    = errors;
                i_rst_n        = 1'b0;
                i_valid        = 1'b0;
                i_sync_hdr     = 2'b00;
                i_test_mode    = 1'b0;
                i_status_clear = 1'b0;
                repeat (10) @(posedge i_clock);
                #1;
                i_rst_n = 1'b1;
                idle(1);
        endtask

        // Lock, then 3 errors in each of two lock windows. 6 in one BER window.
        task automatic lock_and_spread_errors();
                send_blocks(LOCK_COUNT, 1'b0);
                wait_status(LOCK_BIT, 1'b1, WAIT_CYCLES);
                send_blocks(3, 1'b1);
                send_blocks(13, 1'b0);
                send_blocks(3, 1'b1);
        endtask

        task automatic end_test(input string name);
                tests++;
                $display("test %s: %0d errors", name, errors - test_errors);
        endtask

        // ##########################################################
        // Tests
        // ##########################################################

        task automatic test_lock_acquire();
                apply_reset();
                check_outputs(1'b0, 1'b0, 1'b1, 8'd0, 8'd0);
                send_blocks(LOCK_COUNT - 1, 1'b0);
                idle(DRAIN);
                check_outputs(1'b0, 1'b0, 1'b1, 8'd0, 8'd0);
                send_blocks(1, 1'b0);
                wait_status(LOCK_BIT, 1'b1, 3);
                check_outputs(1'b1, 1'b0, 1'b1, 8'd0, 8'd0);
                end_test("lock acquire");
        endtask

        task automatic test_lock_restart();
                apply_reset();
                send_blocks(5, 1'b0);
                send_blocks(1, 1'b1);           // Restarts the good count.
                send_blocks(LOCK_COUNT - 1, 1'b0);
                idle(DRAIN);
                check_outputs(1'b0, 1'b0, 1'b1, 8'd0, 8'd0);
                send_blocks(1, 1'b0);
                wait_status(LOCK_BIT, 1'b1, WAIT_CYCLES);
                check_outputs(1'b1, 1'b0, 1'b1, 8'd0, 8'd0);
                end_test("lock restart");
        endtask

        task automatic test_lock_loss();
                apply_reset();
                send_blocks(LOCK_COUNT, 1'b0);
                wait_status(LOCK_BIT, 1'b1, WAIT_CYCLES);
                send_blocks(3, 1'b1);
                send_blocks(13 + 16, 1'b0);     // Two lock windows, one BER window.
                idle(DRAIN);
                check_outputs(1'b1, 1'b0, 1'b1, 8'd3, 8'd0);
                send_blocks(4, 1'b1);
                wait_status(LOCK_BIT, 1'b0, WAIT_CYCLES);
                check_outputs(1'b0, 1'b0, 1'b1, 8'd7, 8'd0);
                end_test("lock loss");
        endtask

        task automatic test_hi_ber();
                apply_reset();
                lock_and_spread_errors();
                wait_status(HI_BER_BIT, 1'b1, WAIT_CYCLES);
                check_outputs(1'b1, 1'b1, 1'b1, 8'd6, 8'd1);
                send_blocks(13 + 31, 1'b0);     // Clean window short of its last block.
                idle(DRAIN);
                check_outputs(1'b1, 1'b1, 1'b1, 8'd6, 8'd1);
                send_blocks(1, 1'b0);
                wait_status(HI_BER_BIT, 1'b0, WAIT_CYCLES);
                check_outputs(1'b1, 1'b0, 1'b1, 8'd6, 8'd1);
                end_test("hi ber");
        endtask

        task automatic test_test_mode();
                apply_reset();
                i_test_mode = 1'b1;
                lock_and_spread_errors();
                send_blocks(13, 1'b0);
                idle(DRAIN);
                check_outputs(1'b1, 1'b0, 1'b1, 8'd6, 8'd0);
                end_test("test mode");
        endtask

        task automatic test_status_clear();
                int n_err;
                apply_reset();
                lock_and_spread_errors();
                wait_status(HI_BER_BIT, 1'b1, WAIT_CYCLES);
                check_outputs(1'b1, 1'b1, 1'b1, 8'd6, 8'd1);
                i_status_clear = 1'b1;
                idle(1);
                i_status_clear = 1'b0;
                check_outputs(1'b1, 1'b1, 1'b0, 8'd0, 8'd0);
                send_blocks(1, 1'b1);           // Fourth error in this lock window.
                wait_status(LOCK_BIT, 1'b0, WAIT_CYCLES);
                idle(DRAIN);
                check_outputs(1'b0, 1'b0, 1'b1, 8'd1, 8'd0);
                n_err = 1;
                for (int i = 0; i < 65; i++)
                begin
                        send_blocks(LOCK_COUNT, 1'b0);
                        wait_status(LOCK_BIT, 1'b1, WAIT_CYCLES);
                        send_blocks(4, 1'b1);
                        wait_status(LOCK_BIT, 1'b0, WAIT_CYCLES);
                        n_err += 4;
                        check_outputs(1'b0, 1'b0, 1'b1, saturate(n_err), 8'd0);
                end
                end_test("status clear and saturation");
        endtask

        initial
        begin
                i_clock        = 1'b0;
                i_rst_n        = 1'b0;
                i_valid        = 1'b0;
                i_sync_hdr     = 2'b00;
                i_test_mode    = 1'b0;
                i_status_clear = 1'b0;
                test_lock_acquire();
                test_lock_restart();
                test_lock_loss();
                test_hi_ber();
                test_test_mode();
                test_status_clear();
                $display("Tests run %0d, errors %0d", tests, errors);
                if (errors == 0)
                        $display("SIMULATION PASSED");
                else
                        $display("SIMULATION FAILED");
                $finish;
        end

endmodule

/* files.f */
rtl/pcs_rx_pkg.sv
rtl/sync_header_check.sv
rtl/block_lock_fsm.sv
rtl/ber_monitor.sv
rtl/rx_status.sv
rtl/pcs_rx_monitor.sv
dv/tb_pcs_rx_monitor.sv

/* Makefile */
VERILATOR   ?= verilator
FILELIST    ?= files.f
TB_TOP      ?= tb_pcs_rx_monitor
RTL_TOP     ?= pcs_rx_monitor
OBJ_DIR     ?= obj_dir
BUILD_FLAGS ?= --binary --timing -j 0
LINT_FLAGS  ?= --lint-only -Wall
PASS_MSG    ?= SIMULATION PASSED
RTL_SRCS    ?= $(filter rtl/%,$(shell cat $(FILELIST)))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(BUILD_FLAGS) --top-module $(TB_TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TB_TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_SRCS)

clean:
	rm -rf $(OBJ_DIR)
